/* design/mips_pkg.sv */
// shared sizes, boot vector, opcode and funct codes, alu operation codes
`default_nettype none

package mips_pkg;

  // word and register file geometry
  localparam int word_width     = 32;
  localparam int reg_addr_width = 5;
  localparam int reg_count      = 32;   // $zero .. $ra

  localparam logic [word_width-1:0] reset_vector = 32'hBFC00000;  // boot rom base
  localparam logic [word_width-1:0] halt_address = 32'h00000000;  // jump here ends the program

  localparam logic [reg_addr_width-1:0] reg_v0_index = 5'd2;  // $v0, brought out for debug

  // primary opcodes, instr[31:26]
  localparam logic [5:0] op_rtype = 6'h00;  // decoded further by funct
  localparam logic [5:0] op_j     = 6'h02;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_bne   = 6'h05;
  localparam logic [5:0] op_addiu = 6'h09;
  localparam logic [5:0] op_ori   = 6'h0d;
  localparam logic [5:0] op_lui   = 6'h0f;

  // r-type funct codes, instr[5:0]
  localparam logic [5:0] fn_jr   = 6'h08;
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_slt  = 6'h2a;

  // alu operation select
  localparam int alu_op_width = 3;

  localparam logic [alu_op_width-1:0] alu_add    = 3'd0;
  localparam logic [alu_op_width-1:0] alu_sub    = 3'd1;  // also drives the branch compare
  localparam logic [alu_op_width-1:0] alu_and    = 3'd2;
  localparam logic [alu_op_width-1:0] alu_or     = 3'd3;
  localparam logic [alu_op_width-1:0] alu_slt    = 3'd4;  // signed
  localparam logic [alu_op_width-1:0] alu_pass_b = 3'd5;  // lui result comes straight from b

endpackage

`default_nettype wire

/* design/pc_unit.sv */
// program counter register, next-address selection and the active/halt flag
`timescale 1ns/100ps
`default_nettype none

module pc_unit (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            clk_enable,      // low = stall, nothing moves
  input  logic                            branch_taken,    // beq/bne condition already met
  input  logic                            jump,            // j
  input  logic                            jump_register,   // jr
  input  logic [mips_pkg::word_width-1:0] branch_offset,   // sign-extended, in bytes
  input  logic [mips_pkg::word_width-1:0] jump_target,     // {pc+4[31:28], target, 00}
  input  logic [mips_pkg::word_width-1:0] register_target, // rs contents for jr
  output logic [mips_pkg::word_width-1:0] pc,
  output logic [mips_pkg::word_width-1:0] pc_plus4,
  output logic                            active
);

  logic [mips_pkg::word_width-1:0] pc_next;
  logic                            commit;  // this edge retires the current instruction

  assign pc_plus4 = pc + 32'd4;
  assign commit   = clk_enable & active;  // once halted the pc is frozen

  // next address, jr wins over j, j over a taken branch
  always_comb begin
    if (jump_register) begin
      pc_next = register_target;
    end else if (jump) begin
      pc_next = jump_target;
    end else if (branch_taken) begin
      pc_next = pc_plus4 + branch_offset;  // relative to the following instruction
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= mips_pkg::reset_vector;
      active <= 1'b1;
    end else if (commit) begin
      pc <= pc_next;
      // landing on address 0 is the halt convention
      if (pc_next == mips_pkg::halt_address) begin
        active <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* design/instr_decode.sv */
// instruction field split, control decode, immediate extension and jump/branch targets
`timescale 1ns/100ps
`default_nettype none

module instr_decode (
  input  logic [mips_pkg::word_width-1:0]     instr,
  input  logic [mips_pkg::word_width-1:0]     pc_plus4,
  output logic [mips_pkg::reg_addr_width-1:0] rs,
  output logic [mips_pkg::reg_addr_width-1:0] rt,
  output logic [mips_pkg::reg_addr_width-1:0] rd_dest,         // rd or rt, already chosen
  output logic [mips_pkg::word_width-1:0]     immediate,
  output logic                                alu_b_immediate, // b operand from immediate
  output logic [mips_pkg::alu_op_width-1:0]   alu_op,
  output logic                                reg_write,
  output logic                                branch,          // beq
  output logic                                branch_not_equal,
  output logic                                jump,
  output logic                                jump_register,
  output logic [mips_pkg::word_width-1:0]     jump_target,
  output logic [mips_pkg::word_width-1:0]     branch_offset
);

  logic [5:0]                              opcode;
  logic [5:0]                              funct;
  logic [15:0]                             imm16;
  logic [mips_pkg::reg_addr_width-1:0]     rd;
  logic [mips_pkg::word_width-1:0]         imm_sign;  // sign-extended
  logic [mips_pkg::word_width-1:0]         imm_zero;  // zero-extended, ori
  logic [mips_pkg::word_width-1:0]         imm_upper; // lui
  logic                                    is_rtype;

  // fixed field positions
  assign opcode = instr[31:26];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign funct  = instr[5:0];
  assign imm16  = instr[15:0];

  assign imm_sign  = {{16{imm16[15]}}, imm16};
  assign imm_zero  = {16'h0000, imm16};
  assign imm_upper = {imm16, 16'h0000};

  assign is_rtype = (opcode == mips_pkg::op_rtype);
  assign rd_dest  = is_rtype ? rd : rt;  // immediates write rt

  // word offset -> byte offset
  assign branch_offset = {imm_sign[29:0], 2'b00};
  // pseudo-direct, stays in the current 256 MB region
  assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00};

  always_comb begin
    // defaults behave as a no-op
    immediate        = imm_sign;
    alu_b_immediate  = 1'b0;
    alu_op           = mips_pkg::alu_add;
    reg_write        = 1'b0;
    branch           = 1'b0;
    branch_not_equal = 1'b0;
    jump             = 1'b0;
    jump_register    = 1'b0;
    case (opcode)
      mips_pkg::op_rtype: begin
        reg_write = 1'b1;
        case (funct)
          mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
          mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
          mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
          mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
          mips_pkg::fn_slt:  alu_op = mips_pkg::alu_slt;
          mips_pkg::fn_jr: begin
            jump_register = 1'b1;
            reg_write     = 1'b0;  // no link
          end
          default: reg_write = 1'b0;  // unsupported funct
        endcase
      end
      mips_pkg::op_addiu: begin
        alu_b_immediate = 1'b1;
        reg_write       = 1'b1;
      end
      mips_pkg::op_ori: begin
        immediate       = imm_zero;
        alu_b_immediate = 1'b1;
        alu_op          = mips_pkg::alu_or;
        reg_write       = 1'b1;
      end
      mips_pkg::op_lui: begin
        immediate       = imm_upper;
        alu_b_immediate = 1'b1;
        alu_op          = mips_pkg::alu_pass_b;
        reg_write       = 1'b1;
      end
      mips_pkg::op_beq: begin
        alu_op = mips_pkg::alu_sub;  // rs - rt, zero flag decides
        branch = 1'b1;
      end
      mips_pkg::op_bne: begin
        alu_op           = mips_pkg::alu_sub;
        branch_not_equal = 1'b1;
      end
      mips_pkg::op_j:    jump = 1'b1;
      default: ;  // unknown opcode, nothing written
    endcase
  end

endmodule

`default_nettype wire

/* design/alu.sv */
// alu with add, subtract, and, or, signed set-less-than, pass-b and a zero flag
`timescale 1ns/100ps
`default_nettype none

module alu (
  input  logic [mips_pkg::word_width-1:0]   a,
  input  logic [mips_pkg::word_width-1:0]   b,
  input  logic [mips_pkg::alu_op_width-1:0] alu_op,
  output logic [mips_pkg::word_width-1:0]   result,
  output logic                              zero     // result == 0, used by beq/bne
);

  logic less_than;  // signed a < b

  assign less_than = $signed(a) < $signed(b);

  always_comb begin
    case (alu_op)
      mips_pkg::alu_add:    result = a + b;  // no overflow trap, addu semantics
      mips_pkg::alu_sub:    result = a - b;
      mips_pkg::alu_and:    result = a & b;
      mips_pkg::alu_or:     result = a | b;
      mips_pkg::alu_slt: begin
        result = {31'd0, less_than};
      end
      mips_pkg::alu_pass_b: result = b;  // lui
      default:              result = '0;
    endcase
  end

  // branch compare
  assign zero = (result == '0);

endmodule

`default_nettype wire

/* design/regfile.sv */
// 32x32 register file, two combinational reads, one clocked write, $v0 debug output
`timescale 1ns/100ps
`default_nettype none

module regfile (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                write_enable,
  input  logic [mips_pkg::reg_addr_width-1:0] read_addr1,
  input  logic [mips_pkg::reg_addr_width-1:0] read_addr2,
  input  logic [mips_pkg::reg_addr_width-1:0] write_addr,
  input  logic [mips_pkg::word_width-1:0]     write_data,
  output logic [mips_pkg::word_width-1:0]     read_data1,
  output logic [mips_pkg::word_width-1:0]     read_data2,
  output logic [mips_pkg::word_width-1:0]     register_v0  // debug tap on $v0
);

  logic [mips_pkg::word_width-1:0] regs [mips_pkg::reg_count];

  // write port commits on the same edge as the pc
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < mips_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && (write_addr != '0)) begin
      regs[write_addr] <= write_data;  // $zero keeps its reset value
    end
  end

  // asynchronous reads
  assign read_data1 = regs[read_addr1];
  assign read_data2 = regs[read_addr2];

  assign register_v0 = regs[mips_pkg::reg_v0_index];

endmodule

`default_nettype wire

/* design/mips_core.sv */
// single-cycle core top: fetch, decode, execute and register file wiring
`timescale 1ns/100ps
`default_nettype none

module mips_core (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            clk_enable,      // level stall
  input  logic [mips_pkg::word_width-1:0] instr_readdata,  // combinational from memory
  output logic [mips_pkg::word_width-1:0] instr_address,
  output logic                            active,          // low after jump to 0
  output logic [mips_pkg::word_width-1:0] register_v0
);

  // fetch
  logic [mips_pkg::word_width-1:0] pc;
  logic [mips_pkg::word_width-1:0] pc_plus4;

  // decode outputs
  logic [mips_pkg::reg_addr_width-1:0] rs;
  logic [mips_pkg::reg_addr_width-1:0] rt;
  logic [mips_pkg::reg_addr_width-1:0] rd_dest;
  logic [mips_pkg::word_width-1:0]     immediate;
  logic                                alu_b_immediate;
  logic [mips_pkg::alu_op_width-1:0]   alu_op;
  logic                                reg_write;
  logic                                branch;
  logic                                branch_not_equal;
  logic                                jump;
  logic                                jump_register;
  logic [mips_pkg::word_width-1:0]     jump_target;
  logic [mips_pkg::word_width-1:0]     branch_offset;

  // execute
  logic [mips_pkg::word_width-1:0] read_data1;
  logic [mips_pkg::word_width-1:0] read_data2;
  logic [mips_pkg::word_width-1:0] alu_b;
  logic [mips_pkg::word_width-1:0] alu_result;
  logic                            alu_zero;
  logic                            branch_taken;
  logic                            write_enable;  // commit-qualified reg_write

  assign instr_address = pc;

  pc_unit pc_unit_inst (
    .clk             (clk),
    .reset           (reset),
    .clk_enable      (clk_enable),
    .branch_taken    (branch_taken),
    .jump            (jump),
    .jump_register   (jump_register),
    .branch_offset   (branch_offset),
    .jump_target     (jump_target),
    .register_target (read_data1),  // jr uses rs
    .pc              (pc),
    .pc_plus4        (pc_plus4),
    .active          (active)
  );

  instr_decode instr_decode_inst (
    .instr            (instr_readdata),
    .pc_plus4         (pc_plus4),
    .rs               (rs),
    .rt               (rt),
    .rd_dest          (rd_dest),
    .immediate        (immediate),
    .alu_b_immediate  (alu_b_immediate),
    .alu_op           (alu_op),
    .reg_write        (reg_write),
    .branch           (branch),
    .branch_not_equal (branch_not_equal),
    .jump             (jump),
    .jump_register    (jump_register),
    .jump_target      (jump_target),
    .branch_offset    (branch_offset)
  );

  // second operand, register rt or the extended immediate
  assign alu_b = alu_b_immediate ? immediate : read_data2;

  alu alu_inst (
    .a      (read_data1),
    .b      (alu_b),
    .alu_op (alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // beq on equal, bne on not equal
  assign branch_taken = (branch & alu_zero) | (branch_not_equal & ~alu_zero);

  // only a committing instruction may write, never while stalled or halted
  assign write_enable = reg_write & clk_enable & active;

  regfile regfile_inst (
    .clk          (clk),
    .reset        (reset),
    .write_enable (write_enable),
    .read_addr1   (rs),
    .read_addr2   (rt),
    .write_addr   (rd_dest),
    .write_data   (alu_result),
    .read_data1   (read_data1),
    .read_data2   (read_data2),
    .register_v0  (register_v0)
  );

endmodule

`default_nettype wire

/* tests/instr_rom.sv */
// testbench instruction rom with the fixed test program at the boot vector
`timescale 1ns/100ps
`default_nettype none

module instr_rom (
  input  logic [31:0] address,   // byte address from the core
  output logic [31:0] readdata   // combinational within the same cycle
);

  logic [31:0] offset;  // bytes past the boot vector

  assign offset = address - mips_pkg::reset_vector;

  // $t0 = r8, $t1 = r9, $t2 = r10, $t3 = r11, $t4 = r12
  always_comb begin
    if (offset[31:6] != '0) begin
      // anything outside the program bumps $v0 if a halted core still writes
      readdata = 32'h24420001;  // addiu $v0, $v0, 1
    end else begin
      case (offset[5:2])
        4'd0:  readdata = 32'h24000005;  // addiu $zero, $zero, 5
        4'd1:  readdata = 32'h24080001;  // addiu $t0, $zero, 1
        4'd2:  readdata = 32'h2409000B;  // addiu $t1, $zero, 11
        // loop adds $t0 into $v0 until $t0 reaches 11
        4'd3:  readdata = 32'h00481021;  // addu  $v0, $v0, $t0
        4'd4:  readdata = 32'h25080001;  // addiu $t0, $t0, 1
        4'd5:  readdata = 32'h1509FFFD;  // bne   $t0, $t1, loop
        // constant check
        4'd6:  readdata = 32'h3C0A1234;  // lui   $t2, 0x1234
        4'd7:  readdata = 32'h354A5678;  // ori   $t2, $t2, 0x5678
        4'd8:  readdata = 32'h010A582A;  // slt   $t3, $t0, $t2  (expect 1)
        4'd9:  readdata = 32'h240C0001;  // addiu $t4, $zero, 1
        4'd10: readdata = 32'h116C0001;  // beq   $t3, $t4, skip the error add
        4'd11: readdata = 32'h24420064;  // addiu $v0, $v0, 100  (error path)
        4'd12: readdata = 32'h0BF0000E;  // j     word 14
        4'd13: readdata = 32'h24420064;  // addiu $v0, $v0, 100  (jumped over)
        4'd14: readdata = 32'h00000008;  // jr    $zero  (halts the core)
        default: readdata = 32'h00000000;
      endcase
    end
  end

endmodule

`default_nettype wire

/* tests/mips_core_tb.sv */
// testbench for the single-cycle core: clock, reset, random stalls, checks and summary
`timescale 1ns/100ps
`default_nettype none

module mips_core_tb;

  localparam int          timeout_cycles = 2000;   // per wait loop
  localparam int          hold_cycles    = 20;     // frozen window after halt
  localparam logic [31:0] expected_v0    = 32'd55; // 1+..+10, error paths skipped

  logic        clk;
  logic        reset;
  logic        clk_enable;
  logic [31:0] instr_readdata;
  logic [31:0] instr_address;
  logic        active;
  logic [31:0] register_v0;

  integer seed;
  int     errors;
  int     timeouts;
  int     cycles;
  logic   monitoring;   // set when reset drops

  // state seen before an edge, compared after it
  logic        prev_valid;
  logic [31:0] prev_address;
  logic [31:0] prev_v0;
  logic [31:0] prev_instr;   // instruction that commits at that edge
  logic        prev_enable;
  logic        prev_active;

  mips_core mips_core_inst (
    .clk            (clk),
    .reset          (reset),
    .clk_enable     (clk_enable),
    .instr_readdata (instr_readdata),
    .instr_address  (instr_address),
    .active         (active),
    .register_v0    (register_v0)
  );

  instr_rom instr_rom_inst (
    .address  (instr_address),
    .readdata (instr_readdata)
  );

  always #20 clk = ~clk;  // 40 ns period

  // random stall, low about one cycle in four
  always @(posedge clk) begin
    #2;
    clk_enable = (($random(seed) & 32'h3) != 0);
  end

  // j, beq, bne and jr choose their own next address
  function automatic logic changes_flow(input logic [31:0] instr);
    logic [5:0] opcode;
    logic [5:0] funct;
    opcode = instr[31:26];
    funct  = instr[5:0];
    return (opcode == mips_pkg::op_j) || (opcode == mips_pkg::op_beq) ||
           (opcode == mips_pkg::op_bne) ||
           ((opcode == mips_pkg::op_rtype) && (funct == mips_pkg::fn_jr));
  endfunction

  task automatic expect_word(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected) else begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic expect_bit(input string name, input logic actual, input logic expected);
    assert (actual === expected) else begin
      $display("Fail at %0t: %s expected %b, got %b", $time, name, expected, actual);
      errors++;
    end
  endtask

  // outputs settle after the rising edge, sampled on the falling one
  always @(negedge clk) begin
    if (monitoring) begin
      if (prev_valid && !prev_enable) begin
        expect_word("instr_address", instr_address, prev_address);  // stalled edge
        expect_word("register_v0", register_v0, prev_v0);
      end else if (prev_valid && prev_active && !changes_flow(prev_instr)) begin
        expect_word("instr_address", instr_address, prev_address + 32'd4);  // sequential
      end
      prev_valid   = 1'b1;
      prev_address = instr_address;
      prev_v0      = register_v0;
      prev_instr   = instr_readdata;
      prev_enable  = clk_enable;   // holds until 2 ns past the next edge
      prev_active  = active;
    end
  end

  initial begin
    seed         = 32'h3b83;
    clk          = 1'b0;
    reset        = 1'b1;
    clk_enable   = 1'b1;
    errors       = 0;
    timeouts     = 0;
    cycles       = 0;
    monitoring   = 1'b0;
    prev_valid   = 1'b0;
    prev_address = '0;
    prev_v0      = '0;
    prev_instr   = '0;
    prev_enable  = 1'b0;
    prev_active  = 1'b0;

    repeat (5) @(posedge clk);
    #2;
    reset      = 1'b0;
    monitoring = 1'b1;

    @(negedge clk);  // first cycle out of reset
    expect_word("instr_address", instr_address, mips_pkg::reset_vector);
    expect_bit("active", active, 1'b1);
    expect_word("register_v0", register_v0, 32'd0);

    // run until the program jumps to 0
    while (active && (cycles < timeout_cycles)) begin
      @(negedge clk);
      cycles++;
    end

    if (active) begin
      $display("timeout: core still active after %0d cycles, never halted", timeout_cycles);
      timeouts++;
    end else begin
      expect_word("instr_address", instr_address, mips_pkg::halt_address);
      expect_word("register_v0", register_v0, expected_v0);
      repeat (hold_cycles) begin
        @(negedge clk);
        expect_word("instr_address", instr_address, mips_pkg::halt_address);
        expect_bit("active", active, 1'b0);
        expect_word("register_v0", register_v0, expected_v0);
      end
    end

    $display("summary: %0d errors, %0d timeouts", errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
design/mips_pkg.sv
design/pc_unit.sv
design/instr_decode.sv
design/alu.sv
design/regfile.sv
design/mips_core.sv
tests/instr_rom.sv
tests/mips_core_tb.sv

/* Makefile */
# Verilator lint and simulation of the core testbench

TOP := mips_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --assert --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
